// ==== source/matrix_settings.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hub75 panel settings
// geometry, bitplane depth and lit base time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MATRIX_SETTINGS_SVH
`define MATRIX_SETTINGS_SVH

// columns in one row
`define PANEL_WIDTH 64

// rows per half panel, both halves scanned together
`define PANEL_HALF_HEIGHT 16

// bitplanes per colour channel
`define BRIGHTNESS_BITS 4

// lit cycles for the lsb plane
`define OE_BASE_CYCLES 16

`endif

// ==== source/color_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// colour data types
// pixel, pixel pair and host write record
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

package color_pkg;

    // one bcm pixel, 4 bits per channel
    typedef struct packed {
        logic [`BRIGHTNESS_BITS-1:0] r;
        logic [`BRIGHTNESS_BITS-1:0] g;
        logic [`BRIGHTNESS_BITS-1:0] b;
    } rgb_t;

    // top and bottom half pixels at one scan position
    typedef struct packed {
        rgb_t top;
        rgb_t bottom;
    } pixel_pair_t;

    // host write, row spans the full panel height
    typedef struct packed {
        logic [$clog2(2 * `PANEL_HALF_HEIGHT)-1:0] row;
        logic [$clog2(`PANEL_WIDTH)-1:0]           col;
        rgb_t                                      data;
    } pixel_write_t;

endpackage

`default_nettype wire

// ==== source/hub75_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hub75 scan types
// scan position and panel pin bundle
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

package hub75_pkg;

    // where the scan engine is reading right now
    // plane counts down, msb plane first
    typedef struct packed {
        logic [$clog2(`PANEL_HALF_HEIGHT)-1:0] row;
        logic [$clog2(`PANEL_WIDTH)-1:0]       col;
        logic [$clog2(`BRIGHTNESS_BITS)-1:0]   plane;
    } scan_pos_t;

    // panel connector pins
    typedef struct packed {
        // upper half colour bits
        logic r1;
        logic g1;
        logic b1;
        // lower half colour bits
        logic r2;
        logic g2;
        logic b2;
        // row select, follows the latch
        logic [$clog2(`PANEL_HALF_HEIGHT)-1:0] addr;
        logic pclk;
        logic latch;
        // active low output enable
        logic oe_n;
    } hub75_pins_t;

endpackage

`default_nettype wire

// ==== source/interval_counter.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// interval counter
// loadable down-counter, running until zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module interval_counter #(
    parameter int WIDTH = 8
) (
    input  logic             clk_in,
    input  logic             reset,
    input  logic             start,
    input  logic [WIDTH-1:0] value,
    output logic [WIDTH-1:0] counter,
    output logic             running
);

    // load on start, then step down and park at zero
    always_ff @(posedge clk_in) begin
        if (reset) begin
            counter <= '0;
        end else if (start) begin
            counter <= value;
        end else if (running) begin
            counter <= counter - 1'b1;
        end
    end

    assign running = (counter != '0);

    // callers must wait for the interval to finish before reloading
    start_while_idle: assert property (@(posedge clk_in) disable iff (reset)
        start |-> !running);

endmodule

`default_nettype wire

// ==== source/brightness_timeout.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// brightness timeout
// holds oe low for the plane-weighted lit time
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

module brightness_timeout (
    input  logic                                clk_in,
    input  logic                                reset,
    input  logic                                row_latch,
    input  logic [$clog2(`BRIGHTNESS_BITS)-1:0] plane,
    output logic                                oe_n
);

    // msb plane lit time must fit, plus headroom bit
    localparam int MAX_LIT = `OE_BASE_CYCLES << (`BRIGHTNESS_BITS - 1);
    localparam int LIT_W = $clog2(MAX_LIT) + 1;

    logic [LIT_W-1:0] lit_cycles;
    logic             lit_running;

    // binary weight, base time doubled per plane
    assign lit_cycles = LIT_W'(`OE_BASE_CYCLES) << plane;

    interval_counter #(
        .WIDTH(LIT_W)
    ) u_lit_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (row_latch),
        .value  (lit_cycles),
        .counter(),
        .running(lit_running)
    );

    // lit from the cycle after the latch, for lit_cycles cycles
    assign oe_n = !lit_running;

    // latching while lit would glitch the row being shown
    latch_while_dark: assert property (@(posedge clk_in) disable iff (reset)
        row_latch |-> oe_n);

endmodule

`default_nettype wire

// ==== source/matrix_scan.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix scan engine
// columns, latch, bitplanes, rows and pclk
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

module matrix_scan (
    input  logic                                  clk_in,
    input  logic                                  reset,
    output hub75_pkg::scan_pos_t                  pos,
    output logic                                  load,
    output logic                                  pclk,
    output logic                                  row_latch,
    output logic [$clog2(`PANEL_HALF_HEIGHT)-1:0] addr,
    output logic                                  oe_n
);

    localparam int COL_BITS = $clog2(`PANEL_WIDTH);
    localparam int ROW_BITS = $clog2(`PANEL_HALF_HEIGHT);
    localparam int PLANE_BITS = $clog2(`BRIGHTNESS_BITS);
    // two cycles per column, data then clock
    localparam int SHIFT_CYCLES = 2 * `PANEL_WIDTH;
    localparam int TIMER_W = $clog2(SHIFT_CYCLES) + 1;

    logic                  kick;
    logic [TIMER_W-1:0]    col_count;
    logic [TIMER_W-1:0]    col_left;
    logic                  col_running;
    logic                  phase;
    logic                  latch_now;
    logic                  lit_oe_n;
    logic [ROW_BITS-1:0]   row;
    logic [PLANE_BITS-1:0] plane;

    // column timer, 128 down to 1 while shifting
    interval_counter #(
        .WIDTH(TIMER_W)
    ) u_col_timer (
        .clk_in (clk_in),
        .reset  (reset),
        .start  (kick || latch_now),
        .value  (TIMER_W'(SHIFT_CYCLES)),
        .counter(col_count),
        .running(col_running)
    );

    // odd count is the clock half of a column
    assign phase = col_count[0];
    assign col_left = col_count - 1'b1;

    // shift done and previous row dark
    // kick keeps the very first cycle from latching an empty shift
    assign latch_now = !col_running && !kick && lit_oe_n;

    brightness_timeout u_lit (
        .clk_in   (clk_in),
        .reset    (reset),
        .row_latch(latch_now),
        .plane    (plane),
        .oe_n     (lit_oe_n)
    );

    // col runs 63 down to 0, two counts each
    assign pos.row = row;
    assign pos.col = col_left[COL_BITS:1];
    assign pos.plane = plane;
    assign load = col_running && !phase;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            kick <= 1'b1;
            row <= '0;
            plane <= PLANE_BITS'(`BRIGHTNESS_BITS - 1);
            addr <= '0;
            pclk <= 1'b0;
            row_latch <= 1'b0;
            oe_n <= 1'b1;
        end else begin
            kick <= 1'b0;
            // one cycle late, matches store read latency
            pclk <= col_running && phase;
            row_latch <= latch_now;
            oe_n <= lit_oe_n;
            if (latch_now) begin
                // addr shows the row just latched
                addr <= row;
                if (plane == '0) begin
                    // lsb done, next row from msb
                    plane <= PLANE_BITS'(`BRIGHTNESS_BITS - 1);
                    row <= row + 1'b1;
                end else begin
                    plane <= plane - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_store.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame store
// two half-panel rams, host write, scan read
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

module frame_store (
    input  logic                      clk_in,
    input  logic                      wr_en,
    input  color_pkg::pixel_write_t   wr,
    input  hub75_pkg::scan_pos_t      rd_pos,
    output color_pkg::pixel_pair_t    rd_data
);

    localparam int ROW_BITS = $clog2(`PANEL_HALF_HEIGHT);
    localparam int COL_BITS = $clog2(`PANEL_WIDTH);
    localparam int DEPTH = `PANEL_HALF_HEIGHT * `PANEL_WIDTH;

    color_pkg::rgb_t top_mem    [DEPTH];
    color_pkg::rgb_t bottom_mem [DEPTH];

    logic [ROW_BITS+COL_BITS-1:0] wr_addr;
    logic [ROW_BITS+COL_BITS-1:0] rd_addr;

    // row msb picks the half, low bits index within it
    assign wr_addr = {wr.row[ROW_BITS-1:0], wr.col};
    assign rd_addr = {rd_pos.row, rd_pos.col};

    // upper half, rows 0..15
    always_ff @(posedge clk_in) begin
        if (wr_en && !wr.row[ROW_BITS]) begin
            top_mem[wr_addr] <= wr.data;
        end
        rd_data.top <= top_mem[rd_addr];
    end

    // lower half, rows 16..31
    always_ff @(posedge clk_in) begin
        if (wr_en && wr.row[ROW_BITS]) begin
            bottom_mem[wr_addr] <= wr.data;
        end
        rd_data.bottom <= bottom_mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== source/pixel_slicer.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel slicer
// picks plane bits, registers hub75 pins
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

module pixel_slicer (
    input  logic                                  clk_in,
    input  logic                                  reset,
    input  color_pkg::pixel_pair_t                pixels,
    input  logic [$clog2(`BRIGHTNESS_BITS)-1:0]   plane,
    input  logic                                  pclk,
    input  logic                                  row_latch,
    input  logic [$clog2(`PANEL_HALF_HEIGHT)-1:0] addr,
    input  logic                                  oe_n,
    output hub75_pkg::hub75_pins_t                pins
);

    always_ff @(posedge clk_in) begin
        if (reset) begin
            // panel dark, no clocks
            pins <= '0;
            pins.oe_n <= 1'b1;
        end else begin
            // bcm bit for this plane, both halves
            pins.r1 <= pixels.top.r[plane];
            pins.g1 <= pixels.top.g[plane];
            pins.b1 <= pixels.top.b[plane];
            pins.r2 <= pixels.bottom.r[plane];
            pins.g2 <= pixels.bottom.g[plane];
            pins.b2 <= pixels.bottom.b[plane];
            // controls already aligned with the ram read
            pins.addr <= addr;
            pins.pclk <= pclk;
            pins.latch <= row_latch;
            pins.oe_n <= oe_n;
        end
    end

endmodule

`default_nettype wire

// ==== source/hub75_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hub75 controller top
// scan engine, frame store and pin slicer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

module hub75_top (
    input  logic                    clk_in,
    input  logic                    reset,
    input  logic                    wr_en,
    input  color_pkg::pixel_write_t wr,
    output hub75_pkg::hub75_pins_t  pins
);

    hub75_pkg::scan_pos_t                  scan_pos;
    logic                                  scan_load;
    logic                                  scan_pclk;
    logic                                  scan_latch;
    logic [$clog2(`PANEL_HALF_HEIGHT)-1:0] scan_addr;
    logic                                  scan_oe_n;
    color_pkg::pixel_pair_t                pair;
    logic [$clog2(`BRIGHTNESS_BITS)-1:0]   slice_plane;

    matrix_scan u_scan (
        .clk_in   (clk_in),
        .reset    (reset),
        .pos      (scan_pos),
        .load     (scan_load),
        .pclk     (scan_pclk),
        .row_latch(scan_latch),
        .addr     (scan_addr),
        .oe_n     (scan_oe_n)
    );

    frame_store u_store (
        .clk_in (clk_in),
        .wr_en  (wr_en),
        .wr     (wr),
        .rd_pos (scan_pos),
        .rd_data(pair)
    );

    // plane captured with the column read, lines up with pair
    always_ff @(posedge clk_in) begin
        if (scan_load) begin
            slice_plane <= scan_pos.plane;
        end
    end

    pixel_slicer u_slicer (
        .clk_in   (clk_in),
        .reset    (reset),
        .pixels   (pair),
        .plane    (slice_plane),
        .pclk     (scan_pclk),
        .row_latch(scan_latch),
        .addr     (scan_addr),
        .oe_n     (scan_oe_n),
        .pins     (pins)
    );

endmodule

`default_nettype wire

// ==== dv/hub75_top_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// hub75 controller testbench
// random frame fill, scan checked against a model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "matrix_settings.svh"

module hub75_top_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD = 4;
    localparam int ROW_W = $clog2(`PANEL_HALF_HEIGHT);
    localparam int COL_W = $clog2(`PANEL_WIDTH);
    localparam int PLANE_W = $clog2(`BRIGHTNESS_BITS);
    localparam int FRAME_LATCHES = `PANEL_HALF_HEIGHT * `BRIGHTNESS_BITS;
    // worst case per plane, shift and msb lit time back to back
    localparam int PLANE_CYCLES = 2 * `PANEL_WIDTH
        + (`OE_BASE_CYCLES << (`BRIGHTNESS_BITS - 1)) + 2;
    localparam int WATCHDOG_CYCLES = 3 * FRAME_LATCHES * PLANE_CYCLES;

    logic                    clk_in;
    logic                    reset;
    logic                    wr_en;
    color_pkg::pixel_write_t wr;
    hub75_pkg::hub75_pins_t  pins;

    integer seed;
    logic   fill_done;

    // reference copy of every pixel the host wrote
    color_pkg::rgb_t model [2 * `PANEL_HALF_HEIGHT][`PANEL_WIDTH];

    // scan position as seen on the pins
    logic [ROW_W-1:0]   shift_row;
    logic [PLANE_W-1:0] shift_plane;
    logic [PLANE_W-1:0] lit_plane;
    logic [COL_W-1:0]   col_idx;
    logic [ROW_W-1:0]   prev_addr;
    int                 pclk_edges;
    int                 oe_low_len;
    int                 latch_count;
    int                 check_start;
    logic               startup;
    logic               checking;
    logic               prev_pclk;
    logic               prev_latch;
    logic               prev_oe_n;
    logic               pclk_rise;
    logic [5:0]         pin_colors;

    hub75_top u_dut (
        .clk_in(clk_in),
        .reset (reset),
        .wr_en (wr_en),
        .wr    (wr),
        .pins  (pins)
    );

    initial begin
        clk_in = 1'b0;
        forever #HALF_PERIOD clk_in = ~clk_in;
    end

    // expected six colour bits, top half then bottom half
    function automatic logic [5:0] model_bits(input logic [ROW_W-1:0] row,
                                              input logic [PLANE_W-1:0] plane,
                                              input logic [COL_W-1:0] col);
        color_pkg::rgb_t top;
        color_pkg::rgb_t bottom;
        top = model[{1'b0, row}][col];
        bottom = model[{1'b1, row}][col];
        return {top.r[plane], top.g[plane], top.b[plane],
                bottom.r[plane], bottom.g[plane], bottom.b[plane]};
    endfunction

    task automatic report_value(input string name, input int got, input int want);
        $display("FAILED %s got 0x%0h expected 0x%0h", name, got, want);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_event(input string what);
        $display("%s", what);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    // one random pixel per cycle, whole panel
    task automatic fill_frame();
        logic [31:0] rnd;
        for (int r = 0; r < 2 * `PANEL_HALF_HEIGHT; r++) begin
            for (int c = 0; c < `PANEL_WIDTH; c++) begin
                rnd = $random(seed);
                wr_en = 1'b1;
                wr.row = r[ROW_W:0];
                wr.col = c[COL_W-1:0];
                wr.data = rnd[11:0];
                model[r[ROW_W:0]][c[COL_W-1:0]] = rnd[11:0];
                @(posedge clk_in);
                #1;
            end
        end
        wr_en = 1'b0;
    endtask

    assign pclk_rise = pins.pclk && !prev_pclk;
    assign pin_colors = {pins.r1, pins.g1, pins.b1, pins.r2, pins.g2, pins.b2};

    // follows latches and pclk edges on the panel side
    always_ff @(posedge clk_in) begin
        prev_pclk <= pins.pclk;
        prev_latch <= pins.latch;
        prev_oe_n <= pins.oe_n;
        prev_addr <= pins.addr;
        if (reset) begin
            startup <= 1'b1;
            checking <= 1'b0;
            latch_count <= 0;
            check_start <= 0;
            shift_row <= '0;
            shift_plane <= PLANE_W'(`BRIGHTNESS_BITS - 1);
            lit_plane <= '0;
            col_idx <= COL_W'(`PANEL_WIDTH - 1);
            pclk_edges <= 0;
            oe_low_len <= 0;
        end else begin
            if (pclk_rise) begin
                startup <= 1'b0;
            end
            if (pins.latch) begin
                latch_count <= latch_count + 1;
                lit_plane <= shift_plane;
                col_idx <= COL_W'(`PANEL_WIDTH - 1);
                pclk_edges <= 0;
                // msb first, row steps after the lsb plane
                if (shift_plane == '0) begin
                    shift_plane <= PLANE_W'(`BRIGHTNESS_BITS - 1);
                    shift_row <= shift_row + 1'b1;
                end else begin
                    shift_plane <= shift_plane - 1'b1;
                end
                // frame start with the store fully written
                if (fill_done && !checking && (latch_count + 1) % FRAME_LATCHES == 0) begin
                    checking <= 1'b1;
                    check_start <= latch_count + 1;
                end
            end else if (pclk_rise) begin
                col_idx <= col_idx - 1'b1;
                pclk_edges <= pclk_edges + 1;
            end
            if (!pins.oe_n) begin
                oe_low_len <= oe_low_len + 1;
            end else begin
                oe_low_len <= 0;
            end
        end
    end

    startup_dark: assert property (@(posedge clk_in) startup |-> pins.oe_n && !pins.latch)
        else report_event("latch or output enable active before the first shift");
    reset_quiet: assert property (@(posedge clk_in) startup && reset |-> !pins.pclk)
        else report_event("pclk high during reset");
    columns_per_latch: assert property (@(posedge clk_in) disable iff (!checking)
        pins.latch |-> pclk_edges == `PANEL_WIDTH)
        else report_value("pclk_edges", $sampled(pclk_edges), `PANEL_WIDTH);
    column_bits: assert property (@(posedge clk_in) disable iff (!checking)
        pclk_rise |-> pin_colors == model_bits(shift_row, shift_plane, col_idx))
        else report_value("pin_colors", int'($sampled(pin_colors)),
                          int'(model_bits($sampled(shift_row), $sampled(shift_plane),
                                          $sampled(col_idx))));
    lit_after_latch: assert property (@(posedge clk_in) disable iff (!checking)
        prev_latch |-> !pins.oe_n)
        else report_event("oe_n did not go low on the cycle after the latch");
    // weighted lit time, counted when oe_n returns high
    lit_length: assert property (@(posedge clk_in) disable iff (!checking)
        pins.oe_n && !prev_oe_n |-> oe_low_len == (`OE_BASE_CYCLES << lit_plane))
        else report_value("oe_low_len", $sampled(oe_low_len),
                          `OE_BASE_CYCLES << $sampled(lit_plane));
    latch_when_dark: assert property (@(posedge clk_in) disable iff (!checking)
        pins.latch |-> pins.oe_n)
        else report_event("latch pulsed while oe_n was low");
    addr_at_latch: assert property (@(posedge clk_in) disable iff (!checking)
        pins.latch |-> pins.addr == shift_row)
        else report_value("pins.addr", int'($sampled(pins.addr)), int'($sampled(shift_row)));
    addr_steady: assert property (@(posedge clk_in) disable iff (!checking)
        !pins.latch |-> pins.addr == prev_addr)
        else report_value("pins.addr", int'($sampled(pins.addr)), int'($sampled(prev_addr)));

    initial begin
        seed = 32'hd3879030;
        reset = 1'b1;
        wr_en = 1'b0;
        wr = '0;
        fill_done = 1'b0;
        repeat (8) @(posedge clk_in);
        #1;
        reset = 1'b0;
        fill_frame();
        fill_done = 1'b1;
        // two full frames under check
        wait (checking);
        wait (latch_count >= check_start + 2 * FRAME_LATCHES);
        // checks on the last latch settle first
        @(negedge clk_in);
        $display("All checks passed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout, two checked frames did not complete");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+source
source/color_pkg.sv
source/hub75_pkg.sv
source/interval_counter.sv
source/brightness_timeout.sv
source/matrix_scan.sv
source/frame_store.sv
source/pixel_slicer.sv
source/hub75_top.sv
dv/hub75_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hub75 testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module hub75_top_tb -f vlog.f -Mdir obj_dir -o hub75_sim

status=0
./obj_dir/hub75_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "All checks passed" sim.log; then
    exit 0
fi
echo "simulation did not pass (exit status $status)"
exit 1
